// File: all.f
design/apu_regs_pkg.sv
design/apu_audio_pkg.sv
design/apu_reg_decode.sv
design/apu_frame_seq.sv
design/apu_pulse.sv
design/apu_mixer.sv
design/apu_top.sv
sim/apu_assertions.sv
sim/apu_tb.sv

// File: design/apu_audio_pkg.sv
package apu_audio_pkg;

	typedef logic [3:0] volume_t;
	typedef logic [4:0] mix_t;
	typedef logic [10:0] timer_t;
	typedef logic [7:0] length_t;
	typedef logic [1:0] duty_t;

	// Length-load values, indexed by bits 7:3 of register 3
	localparam length_t LENGTH_TABLE [32] = '{
		8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
		8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

	// Sys cycles per timer tick
	localparam int APU_TICK_DIV = 2;

	// Shortened quarter frame for simulation
	localparam int QFRAME_CYCLES = 200;

	localparam int TICK_CNT_W = $clog2(APU_TICK_DIV);
	localparam int QFRAME_CNT_W = $clog2(QFRAME_CYCLES);

endpackage

// File: design/apu_frame_seq.sv
`timescale 1ns/100ps

module apu_frame_seq (
	input  logic clk,
	input  logic rst_n,
	output logic tick,
	output logic qframe,
	output logic hframe
);
	import apu_audio_pkg::*;

	logic [TICK_CNT_W-1:0] tick_cnt;
	logic [QFRAME_CNT_W-1:0] qf_cnt;
	logic qf_end;
	logic half_sel;

	// Timer tick divider
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			tick <= 1'b0;
		end else if (tick_cnt == TICK_CNT_W'(APU_TICK_DIV - 1)) begin
			tick_cnt <= '0;
			tick <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
			tick <= 1'b0;
		end
	end

	assign qf_end = qf_cnt == QFRAME_CNT_W'(QFRAME_CYCLES - 1);

	// Quarter frame counter, every second one is also a half frame
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			qf_cnt <= '0;
			half_sel <= 1'b0;
			qframe <= 1'b0;
			hframe <= 1'b0;
		end else begin
			qframe <= qf_end;
			hframe <= qf_end & half_sel;
			if (qf_end) begin
				qf_cnt <= '0;
				half_sel <= ~half_sel;
			end else begin
				qf_cnt <= qf_cnt + 1'b1;
			end
		end
	end

endmodule

// File: design/apu_mixer.sv
`timescale 1ns/100ps

module apu_mixer (
	input  logic clk,
	input  logic rst_n,
	input  apu_audio_pkg::volume_t level0,
	input  apu_audio_pkg::volume_t level1,
	output apu_audio_pkg::mix_t sample
);
	import apu_audio_pkg::*;

	mix_t sum;

	// Linear sum, both levels widened to avoid overflow
	assign sum = mix_t'(level0) + mix_t'(level1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sample <= '0;
		else
			sample <= sum;
	end

endmodule

// File: design/apu_pulse.sv
`timescale 1ns/100ps

module apu_pulse #(
	parameter logic defect = 1'b0
) (
	input  logic clk,
	input  logic rst_n,
	input  logic tick,
	input  logic qframe,
	input  logic hframe,
	input  logic sel,
	input  logic en,
	input  logic reg_we,
	input  apu_regs_pkg::reg_index_t reg_index,
	input  apu_regs_pkg::bus_data_t reg_wdata,
	output logic act,
	output apu_audio_pkg::volume_t level
);
	import apu_regs_pkg::*;
	import apu_audio_pkg::*;

	logic we;
	logic we1;
	logic we3;
	bus_data_t regs [4];

	assign we = sel & reg_we;
	assign we1 = we & (reg_index == 2'd1);
	assign we3 = we & (reg_index == 2'd3);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end else if (!en) begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[reg_index] <= reg_wdata;
		end
	end

	// Register fields
	duty_t duty;
	logic lc_halt;
	logic env_loop;
	logic vol_const;
	volume_t env_param;
	logic swp_en;
	logic [2:0] swp_period;
	logic swp_neg;
	logic [2:0] swp_shift;
	logic [4:0] lc_index;

	assign duty = regs[0][7:6];
	assign lc_halt = regs[0][5];
	assign env_loop = lc_halt;
	assign vol_const = regs[0][4];
	assign env_param = regs[0][3:0];
	assign swp_en = regs[1][7];
	assign swp_period = regs[1][6:4];
	assign swp_neg = regs[1][3];
	assign swp_shift = regs[1][2:0];
	assign lc_index = regs[3][7:3];

	// Envelope restart waits for the next quarter frame
	logic env_start;
	volume_t env_div;
	volume_t env_cnt;
	volume_t env_out;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			env_start <= 1'b0;
		else if (!en)
			env_start <= 1'b0;
		else if (we3)
			env_start <= 1'b1;
		else if (qframe)
			env_start <= 1'b0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			env_div <= '0;
			env_cnt <= '0;
		end else if (qframe) begin
			if (env_start) begin
				env_div <= env_param;
				env_cnt <= 4'hf;
			end else if (env_div == '0) begin
				env_div <= env_param;
				// Wraps from 0 back to 15 in loop mode
				if (env_loop || env_cnt != '0)
					env_cnt <= env_cnt - 4'd1;
			end else begin
				env_div <= env_div - 4'd1;
			end
		end
	end

	assign env_out = vol_const ? env_param : env_cnt;

	// Timer period, from the CPU or from the sweep unit
	timer_t timer_load;
	timer_t swp_target;
	logic swp_apply;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			timer_load <= '0;
		else if (!en)
			timer_load <= '0;
		else if (we3)
			timer_load <= {reg_wdata[2:0], regs[2]};
		else if (hframe && swp_apply)
			timer_load <= swp_target;
	end

	timer_t timer_cnt;
	logic timer_tick;
	logic gate_timer;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_cnt <= '0;
			timer_tick <= 1'b0;
			gate_timer <= 1'b0;
		end else if (!en) begin
			timer_cnt <= '0;
			timer_tick <= 1'b0;
			gate_timer <= 1'b0;
		end else begin
			timer_tick <= 1'b0;
			if (tick) begin
				if (timer_cnt == '0) begin
					timer_cnt <= timer_load;
					timer_tick <= 1'b1;
					// Periods below 8 are silent
					gate_timer <= timer_load[10:3] != '0;
				end else begin
					timer_cnt <= timer_cnt - 11'd1;
				end
			end
		end
	end

	// Sweep
	logic swp_reload;
	timer_t swp_delta;
	logic swp_carry;
	logic swp_ovf;
	logic gate_swp;
	logic [2:0] swp_div;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			swp_reload <= 1'b0;
		else if (!en)
			swp_reload <= 1'b0;
		else if (we1)
			swp_reload <= 1'b1;
		else if (hframe)
			swp_reload <= 1'b0;
	end

	// Pulse 0 negates with ones' complement, pulse 1 with two's complement
	assign swp_delta = (timer_load >> swp_shift) ^ {11{swp_neg}};
	assign {swp_carry, swp_target} = {1'b0, timer_load} + {1'b0, swp_delta}
		+ {11'd0, ~defect & swp_neg};
	assign swp_ovf = swp_neg ^ swp_carry;
	assign gate_swp = swp_neg | ~swp_carry;
	assign swp_apply = swp_en && swp_div == 3'd0 && swp_shift != 3'd0 && !swp_ovf;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			swp_div <= '0;
		end else if (hframe) begin
			if (swp_reload)
				swp_div <= swp_period;
			else if (swp_div == '0) begin
				if (swp_en)
					swp_div <= swp_period;
			end else begin
				swp_div <= swp_div - 3'd1;
			end
		end
	end

	// Duty sequencer
	logic [2:0] seq_step;
	logic gate_seq;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			seq_step <= '0;
		else if (!en)
			seq_step <= '0;
		else if (timer_tick)
			seq_step <= seq_step - 3'd1;
	end

	always_comb begin
		case (duty)
			2'd0: gate_seq = seq_step == 3'b111;
			2'd1: gate_seq = seq_step[2:1] == 2'b11;
			2'd2: gate_seq = seq_step[2];
			2'd3: gate_seq = seq_step[2:1] != 2'b11;
			default: gate_seq = 1'b0;
		endcase
	end

	// Length counter, loaded at the half frame after a register 3 write
	logic load_lc;
	length_t lc_cnt;
	length_t lc_next;
	logic gate_lc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			load_lc <= 1'b0;
		else if (!en)
			load_lc <= 1'b0;
		else if (we3)
			load_lc <= 1'b1;
		else if (hframe)
			load_lc <= 1'b0;
	end

	always_comb begin
		lc_next = lc_cnt;
		if (load_lc)
			lc_next = LENGTH_TABLE[lc_index];
		else if (!lc_halt && lc_cnt != '0)
			lc_next = lc_cnt - 8'd1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lc_cnt <= '0;
			gate_lc <= 1'b0;
		end else if (!en) begin
			lc_cnt <= '0;
			gate_lc <= 1'b0;
		end else if (hframe) begin
			lc_cnt <= lc_next;
			gate_lc <= lc_next != '0;
		end
	end

	assign act = en & gate_lc;

	// Output gate
	logic gate;

	assign gate = en & gate_lc & gate_timer & gate_seq & gate_swp;
	assign level = gate ? env_out : '0;

endmodule

// File: design/apu_reg_decode.sv
`timescale 1ns/100ps

module apu_reg_decode (
	input  logic clk,
	input  logic rst_n,
	input  logic bus_we,
	input  apu_regs_pkg::bus_addr_t bus_addr,
	input  apu_regs_pkg::bus_data_t bus_wdata,
	output logic sel0,
	output logic sel1,
	output logic reg_we,
	output apu_regs_pkg::reg_index_t reg_index,
	output apu_regs_pkg::bus_data_t reg_wdata,
	output logic en0,
	output logic en1
);
	import apu_regs_pkg::*;

	logic status_we;

	// Channel windows differ only in the upper address bits
	assign sel0 = bus_addr[4:2] == ADDR_PULSE0_BASE[4:2];
	assign sel1 = bus_addr[4:2] == ADDR_PULSE1_BASE[4:2];

	assign reg_we = bus_we & (sel0 | sel1);
	assign reg_index = bus_addr[1:0];
	assign reg_wdata = bus_wdata;

	assign status_we = bus_we & (bus_addr == ADDR_STATUS);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en0 <= 1'b0;
			en1 <= 1'b0;
		end else if (status_we) begin
			en0 <= bus_wdata[0];
			en1 <= bus_wdata[1];
		end
	end

endmodule

// File: design/apu_regs_pkg.sv
package apu_regs_pkg;

	// Register offsets relative to 0x4000
	typedef logic [4:0] bus_addr_t;

	// CPU write data
	typedef logic [7:0] bus_data_t;

	// One of the four registers of a channel
	typedef logic [1:0] reg_index_t;

	// Channel windows, four registers each
	localparam bus_addr_t ADDR_PULSE0_BASE = 5'h00;
	localparam bus_addr_t ADDR_PULSE1_BASE = 5'h04;

	// Channel-enable register, bit 0 for pulse 0 and bit 1 for pulse 1
	localparam bus_addr_t ADDR_STATUS = 5'h15;

endpackage

// File: design/apu_top.sv
`timescale 1ns/100ps

module apu_top (
	input  logic clk,
	input  logic rst_n,
	input  logic bus_we,
	input  apu_regs_pkg::bus_addr_t bus_addr,
	input  apu_regs_pkg::bus_data_t bus_wdata,
	output apu_audio_pkg::mix_t sample,
	output logic act0,
	output logic act1
);
	import apu_regs_pkg::*;
	import apu_audio_pkg::*;

	logic sel0;
	logic sel1;
	logic reg_we;
	reg_index_t reg_index;
	bus_data_t reg_wdata;
	logic en0;
	logic en1;
	logic tick;
	logic qframe;
	logic hframe;
	volume_t level0;
	volume_t level1;

	apu_reg_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.bus_we(bus_we),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.sel0(sel0),
		.sel1(sel1),
		.reg_we(reg_we),
		.reg_index(reg_index),
		.reg_wdata(reg_wdata),
		.en0(en0),
		.en1(en1)
	);

	apu_frame_seq u_frame_seq (
		.clk(clk),
		.rst_n(rst_n),
		.tick(tick),
		.qframe(qframe),
		.hframe(hframe)
	);

	apu_pulse #(.defect(1'b1)) pulse0 (
		.clk(clk),
		.rst_n(rst_n),
		.tick(tick),
		.qframe(qframe),
		.hframe(hframe),
		.sel(sel0),
		.en(en0),
		.reg_we(reg_we),
		.reg_index(reg_index),
		.reg_wdata(reg_wdata),
		.act(act0),
		.level(level0)
	);

	apu_pulse #(.defect(1'b0)) pulse1 (
		.clk(clk),
		.rst_n(rst_n),
		.tick(tick),
		.qframe(qframe),
		.hframe(hframe),
		.sel(sel1),
		.en(en1),
		.reg_we(reg_we),
		.reg_index(reg_index),
		.reg_wdata(reg_wdata),
		.act(act1),
		.level(level1)
	);

	apu_mixer u_mixer (
		.clk(clk),
		.rst_n(rst_n),
		.level0(level0),
		.level1(level1),
		.sample(sample)
	);

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module apu_tb -f all.f -o apu_sim

out=$(./obj_dir/apu_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
	exit 0
else
	exit 1
fi

// File: sim/apu_assertions.sv
`timescale 1ns/100ps

module apu_assertions (
	input logic clk,
	input logic rst_n,
	input logic qframe,
	input logic hframe,
	input logic en0,
	input logic en1,
	input logic act0,
	input logic act1,
	input apu_audio_pkg::mix_t sample
);
	import apu_audio_pkg::*;

	// Every half frame is also a quarter frame
	hframe_on_qframe: assert property (@(posedge clk) disable iff (!rst_n) hframe |-> qframe)
		else $error("hframe strobe without qframe");

	// Act stays low while disabled and for one cycle after re-enable
	act0_off: assert property (@(posedge clk) disable iff (!rst_n)
		!en0 |-> !act0 ##1 !act0)
		else $error("act0 high while pulse 0 is disabled or just re-enabled");

	act1_off: assert property (@(posedge clk) disable iff (!rst_n)
		!en1 |-> !act1 ##1 !act1)
		else $error("act1 high while pulse 1 is disabled or just re-enabled");

	// Two 4-bit levels cannot sum past 30
	sample_range: assert property (@(posedge clk) disable iff (!rst_n) sample <= mix_t'(30))
		else $error("sample above 30");

endmodule

bind apu_top apu_assertions u_assertions (
	.clk(clk),
	.rst_n(rst_n),
	.qframe(qframe),
	.hframe(hframe),
	.en0(en0),
	.en1(en1),
	.act0(act0),
	.act1(act1),
	.sample(sample)
);

// File: sim/apu_stimulus.txt
# w addr data (hex, addr is the offset from 0x4000) | h half_frames
# e act0 act1 peak_sample (decimal, peak over one duty period or more)
e 0 0 0
w 00 f9
w 03 08
h 1
e 0 0 0
w 15 03
w 00 f9
w 01 00
w 02 08
w 03 08
w 04 f5
w 05 00
w 06 08
w 07 08
h 1
e 1 1 14
# Length counter, table entry 0 loads 10
w 00 d9
w 03 00
h 8
e 1 1 14
h 4
e 0 1 5
w 00 f9
w 03 00
h 13
e 1 1 14
# Envelope decay without and with loop
w 00 c0
w 03 08
h 10
e 1 1 5
h 1
w 00 e0
w 03 08
h 8
e 1 1 20
# Timer period below 8, then sweep overflow
w 00 f9
w 02 05
w 03 08
h 1
e 1 1 5
w 01 01
w 02 f0
w 03 0f
h 1
e 1 1 5
# Restart pulse 0, then disable pulse 1
w 15 02
w 15 03
w 00 f9
w 01 00
w 02 08
w 03 08
h 1
e 1 1 14
w 15 01
h 1
e 1 0 9

// File: sim/apu_tb.sv
`timescale 1ns/100ps

module apu_tb;
	import apu_regs_pkg::*;
	import apu_audio_pkg::*;

	localparam int CLK_NS = 40;
	localparam int HFRAME_NS = 2 * QFRAME_CYCLES * CLK_NS;
	localparam int PEAK_SKIP = 2;
	// Stops short of the next half frame
	localparam int PEAK_CYCLES = 2 * QFRAME_CYCLES - 12;

	logic clk;
	logic rst_n;
	logic bus_we;
	bus_addr_t bus_addr;
	bus_data_t bus_wdata;
	mix_t sample;
	logic act0;
	logic act1;

	byte cmd_q [$];
	int arg_a_q [$];
	int arg_b_q [$];
	int arg_c_q [$];
	longint limit_ns;
	int checks;

	apu_top apu_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.bus_we(bus_we),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.sample(sample),
		.act0(act0),
		.act1(act1)
	);

	always #(CLK_NS / 2) clk = ~clk;

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_mix(input string name, input mix_t got, input mix_t exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Sample check failed");
		end
	endtask

	task automatic check_act(input string name, input logic [1:0] got, input logic [1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Active flag check failed");
		end
	endtask

	task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
		bus_we = 1'b1;
		bus_addr = addr;
		bus_wdata = data;
		next_cycle();
		bus_we = 1'b0;
	endtask

	// Returns just after the DUT has taken the last counted strobe
	task automatic wait_hframes(input int count);
		int seen;
		seen = 0;
		while (seen < count) begin
			next_cycle();
			if (apu_top_i.hframe)
				seen++;
		end
		next_cycle();
	endtask

	task automatic expect_state(input logic [1:0] act_exp, input mix_t peak_exp);
		mix_t peak;
		peak = '0;
		check_act("act0,act1", {act0, act1}, act_exp);
		repeat (PEAK_SKIP) next_cycle();
		repeat (PEAK_CYCLES) begin
			next_cycle();
			if (sample > peak)
				peak = sample;
		end
		check_mix("sample peak", peak, peak_exp);
	endtask

	task automatic load_stimulus();
		int fd;
		int n;
		int a;
		int b;
		int c;
		int writes;
		int waits;
		int expects;
		longint frames;
		string line;
		byte cmd;
		writes = 0;
		waits = 0;
		expects = 0;
		frames = 0;
		fd = $fopen("sim/apu_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file sim/apu_stimulus.txt");
			$display("TEST RESULT: FAIL");
			$fatal(1, "Missing stimulus file");
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != "#") begin
				cmd = line.getc(0);
				a = 0;
				b = 0;
				c = 0;
				// Bus writes are hex, the rest decimal
				if (cmd == "w")
					n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
				else
					n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d", a, b, c);
				cmd_q.push_back(cmd);
				arg_a_q.push_back(a);
				arg_b_q.push_back(b);
				arg_c_q.push_back(c);
				if (cmd == "w")
					writes++;
				else if (cmd == "h") begin
					waits++;
					frames += a;
				end else
					expects++;
			end
		end
		$fclose(fd);
		limit_ns = (frames + waits + expects + 4) * HFRAME_NS + (writes + 40) * CLK_NS;
	endtask

	task automatic run_stimulus();
		for (int i = 0; i < cmd_q.size(); i++) begin
			case (cmd_q[i])
				"w": bus_write(bus_addr_t'(arg_a_q[i]), bus_data_t'(arg_b_q[i]));
				"h": wait_hframes(arg_a_q[i]);
				"e": expect_state({arg_a_q[i] != 0, arg_b_q[i] != 0}, mix_t'(arg_c_q[i]));
				default: begin
					$display("Unknown command on stimulus line %0d", i + 1);
					$display("TEST RESULT: FAIL");
					$fatal(1, "Bad stimulus");
				end
			endcase
		end
	endtask

	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("Timeout: the stimulus did not complete within %0d ns", limit_ns);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Timeout");
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		bus_we = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		checks = 0;
		limit_ns = 0;
		load_stimulus();
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		run_stimulus();
		if (checks == 0) begin
			$display("No checks were found in the stimulus file");
			$display("TEST RESULT: FAIL");
		end else begin
			$display("TEST RESULT: PASS");
		end
		$finish;
	end

endmodule
